// ==== verilog/tnn_cfg_pkg.sv ====
`default_nettype none

package tnn_cfg_pkg;

    localparam int feat_cnt   = 11;
    localparam int feat_bits  = 4;
    localparam int hidden_cnt = 40;
    localparam int class_cnt  = 6;

    localparam int sum_bits   = $clog2(hidden_cnt + 1); // popcount of up to 40 agreeing bits
    localparam int score_bits = sum_bits + 1;           // room for the doubled count plus bias
    localparam int index_bits = $clog2(feat_cnt + 1) + feat_bits;
    localparam int class_bits = $clog2(class_cnt);

    typedef logic [feat_bits-1:0]  feature_t;
    typedef logic [hidden_cnt-1:0] hidden_t;
    typedef logic [class_bits-1:0] class_t;
    typedef logic [score_bits-1:0] score_t;

    // the input bus is seen either as one flat word or as eleven nibbles,
    // with feature 0 in the top nibble
    typedef union packed {
        logic [feat_cnt*feat_bits-1:0] flat;
        feature_t [0:feat_cnt-1]       field;
    } feature_word_t;

endpackage

`default_nettype wire

// ==== verilog/tnn_weights_pkg.sv ====
`default_nettype none

package tnn_weights_pkg;

    import tnn_cfg_pkg::*;

    // bit k of a mask selects feature k, four neurons per line
    localparam logic [feat_cnt-1:0] pos_mask [hidden_cnt] = '{
        11'b01000100100, 11'b00101000000, 11'b00000000000, 11'b00101010000,
        11'b00000010110, 11'b01001100110, 11'b00000000000, 11'b10010000100,
        11'b00001011110, 11'b10000001111, 11'b01000000000, 11'b10000000000,
        11'b10000000010, 11'b10101100101, 11'b00011101110, 11'b00001000010,
        11'b10010000000, 11'b01001000101, 11'b10111100100, 11'b10010100000,
        11'b01010000000, 11'b00000101000, 11'b11001010001, 11'b00100100101,
        11'b00010110100, 11'b10000101000, 11'b00100101101, 11'b10000010001,
        11'b00010000110, 11'b00001010011, 11'b10100000101, 11'b00010001000,
        11'b10100101101, 11'b11001000000, 11'b00001000001, 11'b01000100001,
        11'b00000011001, 11'b00000000000, 11'b00011011011, 11'b00011100000
    };

    localparam logic [feat_cnt-1:0] neg_mask [hidden_cnt] = '{
        11'b00011011011, 11'b10000101001, 11'b00000000000, 11'b10000100000,
        11'b11110100000, 11'b00110000001, 11'b00000000000, 11'b00001110001,
        11'b11000000001, 11'b00000100000, 11'b00011000110, 11'b00011100110,
        11'b01010100100, 11'b01000000010, 11'b00000010000, 11'b01100000000,
        11'b00100101110, 11'b10000110000, 11'b00000010000, 11'b01101000001,
        11'b00000000101, 11'b11100010001, 11'b00000000010, 11'b00001011010,
        11'b11100001000, 11'b00101000010, 11'b11010010010, 11'b00001000100,
        11'b01001000000, 11'b01000000100, 11'b01011100000, 11'b11000000010,
        11'b00010000010, 11'b00000011101, 11'b11100000100, 11'b00111001100,
        11'b00010100010, 11'b00000000000, 11'b00100000000, 11'b11100000100
    };

    // hidden bits that vote for a class when set
    localparam hidden_t class_true_mask [class_cnt] = '{
        40'h8050400014,
        40'h0820002E00,
        40'h0200006110,
        40'h0300800040,
        40'h3300404884,
        40'h2A42002040
    };

    // hidden bits that vote for a class when clear
    localparam hidden_t class_inv_mask [class_cnt] = '{
        40'h0024861009,
        40'h0010000020,
        40'h0802001203,
        40'h8400001002,
        40'h00A210900B,
        40'h0000005111
    };

    localparam score_t class_bias [class_cnt] = '{4, 10, 7, 10, 0, 6};

endpackage

`default_nettype wire

// ==== verilog/argmax.sv ====
`timescale 1ns/1ps
`default_nettype none

module argmax (
    input  tnn_cfg_pkg::score_t scores [tnn_cfg_pkg::class_cnt],
    output tnn_cfg_pkg::class_t index_max
);

    import tnn_cfg_pkg::*;

    score_t best;

    // strictly greater replaces the best, so the lowest index keeps a tie
    always_comb begin
        best      = scores[0];
        index_max = '0;
        for (int c = 1; c < class_cnt; c++) begin
            if (scores[c] > best) begin
                best      = scores[c];
                index_max = class_t'(c);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/feature_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module feature_capture (
    input  logic                       clk,
    input  logic                       reset,
    input  tnn_cfg_pkg::feature_word_t features,
    input  logic                       features_valid,
    output tnn_cfg_pkg::feature_word_t feature_reg,
    output logic                       feature_valid_q
);

    // the word is only loaded on a strobe so the neurons see a stable sample in between
    always_ff @(posedge clk) begin
        if (reset) begin
            feature_reg <= '0;
        end else if (features_valid) begin
            feature_reg <= features;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            feature_valid_q <= 1'b0;
        end else begin
            feature_valid_q <= features_valid;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ternary_neuron.sv ====
`timescale 1ns/1ps
`default_nettype none

module ternary_neuron #(
    parameter int neuron_id = 0
) (
    input  logic                       clk,
    input  logic                       reset,
    input  tnn_cfg_pkg::feature_word_t feature_reg,
    output logic                       hidden_bit
);

    import tnn_cfg_pkg::*;
    import tnn_weights_pkg::*;

    localparam logic [feat_cnt-1:0] pos_sel = pos_mask[neuron_id];
    localparam logic [feat_cnt-1:0] neg_sel = neg_mask[neuron_id];
    localparam bit has_weights = |{pos_sel, neg_sel}; // pruned neurons never fire

    logic [index_bits-1:0] pos_sum;
    logic [index_bits-1:0] neg_sum;

    always_comb begin
        pos_sum = '0;
        neg_sum = '0;
        for (int k = 0; k < feat_cnt; k++) begin
            if (pos_sel[k]) begin
                pos_sum = pos_sum + index_bits'(feature_reg.field[k]);
            end
            if (neg_sel[k]) begin
                neg_sum = neg_sum + index_bits'(feature_reg.field[k]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hidden_bit <= 1'b0;
        end else begin
            hidden_bit <= has_weights && (pos_sum >= neg_sum); // ties count as firing
        end
    end

endmodule

`default_nettype wire

// ==== verilog/class_scorer.sv ====
`timescale 1ns/1ps
`default_nettype none

module class_scorer (
    input  logic                 clk,
    input  logic                 reset,
    input  tnn_cfg_pkg::hidden_t hidden_reg,
    input  logic                 hidden_valid,
    output tnn_cfg_pkg::class_t  prediction,
    output logic                 prediction_valid
);

    import tnn_cfg_pkg::*;
    import tnn_weights_pkg::*;

    hidden_t             agree [class_cnt];
    logic [sum_bits-1:0] count [class_cnt];
    score_t              scores [class_cnt];
    class_t              index_max;

    always_comb begin
        for (int c = 0; c < class_cnt; c++) begin
            // a bit agrees when it matches the polarity the class expects
            agree[c] = (hidden_reg & class_true_mask[c]) | (~hidden_reg & class_inv_mask[c]);
            count[c] = '0;
            for (int h = 0; h < hidden_cnt; h++) begin
                count[c] = count[c] + sum_bits'(agree[c][h]);
            end
            scores[c] = score_t'({count[c], 1'b0}) + class_bias[c];
        end
    end

    argmax argmax_inst (
        .scores    (scores),
        .index_max (index_max)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            prediction       <= '0;
            prediction_valid <= 1'b0;
        end else begin
            prediction_valid <= hidden_valid;
            if (hidden_valid) begin
                prediction <= index_max; // held until the next valid result
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tnn_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

module tnn_classifier (
    input  logic                       clk,
    input  logic                       reset,
    input  tnn_cfg_pkg::feature_word_t features,
    input  logic                       features_valid,
    output tnn_cfg_pkg::class_t        prediction,
    output logic                       prediction_valid
);

    import tnn_cfg_pkg::*;

    feature_word_t feature_reg;
    logic          feature_valid_q;
    hidden_t       hidden_reg;
    logic          hidden_valid;

    feature_capture feature_capture_inst (
        .clk             (clk),
        .reset           (reset),
        .features        (features),
        .features_valid  (features_valid),
        .feature_reg     (feature_reg),
        .feature_valid_q (feature_valid_q)
    );

    generate
        for (genvar n = 0; n < hidden_cnt; n++) begin : g_neuron
            ternary_neuron #(
                .neuron_id (n)
            ) ternary_neuron_inst (
                .clk         (clk),
                .reset       (reset),
                .feature_reg (feature_reg),
                .hidden_bit  (hidden_reg[n])
            );
        end
    endgenerate

    // the neurons carry no valid of their own, the strobe follows them here
    always_ff @(posedge clk) begin
        if (reset) begin
            hidden_valid <= 1'b0;
        end else begin
            hidden_valid <= feature_valid_q;
        end
    end

    class_scorer class_scorer_inst (
        .clk              (clk),
        .reset            (reset),
        .hidden_reg       (hidden_reg),
        .hidden_valid     (hidden_valid),
        .prediction       (prediction),
        .prediction_valid (prediction_valid)
    );

endmodule

`default_nettype wire

// ==== tb/tnn_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tnn_clock_gen #(
    parameter int period_ns = 40
) (
    output logic clk
);

    initial clk = 1'b0;

    always begin
        #(period_ns / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== tb/tnn_classifier_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tnn_classifier_tb;

    import tnn_cfg_pkg::*;
    import tnn_weights_pkg::*;

    localparam int clk_period       = 40;
    localparam int drive_delay      = 2;
    localparam int reset_cycles     = 3;
    localparam int random_count     = 200;
    localparam int stream_count     = 50;
    localparam int tie_search_limit = 100000;
    // cycles of each test in order with a random sample taking at most seven
    localparam int test_cycles  = 8 + 4 + 3 * 4 + random_count * 7 + stream_count + 3 + 15;
    localparam int watchdog_ns  = clk_period * (reset_cycles + test_cycles + 100);

    logic          clk;
    logic          reset;
    feature_word_t features;
    logic          features_valid;
    class_t        prediction;
    logic          prediction_valid;

    tnn_clock_gen #(
        .period_ns (clk_period)
    ) tnn_clock_gen_inst (
        .clk (clk)
    );

    tnn_classifier tnn_classifier_inst (
        .clk              (clk),
        .reset            (reset),
        .features         (features),
        .features_valid   (features_valid),
        .prediction       (prediction),
        .prediction_valid (prediction_valid)
    );

    // feature 0 is taken from the top nibble of the flat bus
    function automatic hidden_t model_hidden(input feature_word_t word);
        int      value [feat_cnt];
        int      pos_total;
        int      neg_total;
        hidden_t hidden;
        for (int k = 0; k < feat_cnt; k++) begin
            value[k] = int'(word.flat[(feat_cnt - 1 - k) * feat_bits +: feat_bits]);
        end
        for (int n = 0; n < hidden_cnt; n++) begin
            pos_total = 0;
            neg_total = 0;
            for (int k = 0; k < feat_cnt; k++) begin
                if (pos_mask[n][k]) pos_total += value[k];
                if (neg_mask[n][k]) neg_total += value[k];
            end
            hidden[n] = ((pos_mask[n] | neg_mask[n]) != '0) && (pos_total >= neg_total);
        end
        return hidden;
    endfunction

    function automatic int model_score(input hidden_t hidden, input int c);
        int agree_cnt;
        agree_cnt = 0;
        for (int n = 0; n < hidden_cnt; n++) begin
            if (class_true_mask[c][n] && hidden[n]) agree_cnt++;
            if (class_inv_mask[c][n] && !hidden[n]) agree_cnt++;
        end
        return 2 * agree_cnt + int'(class_bias[c]);
    endfunction

    function automatic class_t model_class(input feature_word_t word);
        hidden_t hidden;
        int      score;
        int      best_score;
        class_t  best_class;
        hidden     = model_hidden(word);
        best_score = -1;
        best_class = '0;
        for (int c = 0; c < class_cnt; c++) begin
            score = model_score(hidden, c);
            if (score > best_score) begin // a tie keeps the lower class
                best_score = score;
                best_class = class_t'(c);
            end
        end
        return best_class;
    endfunction

    function automatic bit top_score_tied(input feature_word_t word);
        hidden_t hidden;
        int      score [class_cnt];
        int      best_score;
        int      hits;
        hidden     = model_hidden(word);
        best_score = -1;
        hits       = 0;
        for (int c = 0; c < class_cnt; c++) begin
            score[c] = model_score(hidden, c);
            if (score[c] > best_score) begin
                best_score = score[c];
            end
        end
        for (int c = 0; c < class_cnt; c++) begin
            if (score[c] == best_score) hits++;
        end
        return hits > 1;
    endfunction

    function automatic logic [feat_cnt*feat_bits-1:0] random_word();
        return {12'($urandom()), $urandom()};
    endfunction

    task automatic check_class(input string name, input class_t expected, input class_t actual);
        if (actual !== expected) begin
            $display("error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic check_hidden(input string name, input hidden_t expected, input hidden_t actual);
        if (actual !== expected) begin
            $display("error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #(drive_delay);
    endtask

    task automatic send_sample(input feature_word_t word);
        features       = word;
        features_valid = 1'b1;
        next_cycle();
        features_valid = 1'b0;
    endtask

    task automatic wait_result(input int limit);
        int waited;
        waited = 0;
        while (!prediction_valid) begin
            if (waited >= limit) begin
                $display("no prediction_valid seen within %0d cycles", limit);
                $display("Simulation failed");
                $fatal(1);
            end
            next_cycle();
            waited++;
        end
    endtask

    task automatic test_reset();
        repeat (8) begin
            check_bit("prediction_valid", 1'b0, prediction_valid);
            check_class("prediction", '0, prediction);
            next_cycle();
        end
    endtask

    task automatic test_latency();
        feature_word_t word;
        class_t        expected;
        word.flat = random_word();
        expected  = model_class(word);
        features       = word;
        features_valid = 1'b1;
        for (int i = 1; i <= 3; i++) begin
            next_cycle();
            features_valid = 1'b0;
            check_bit("prediction_valid", i == 3, prediction_valid);
        end
        check_class("prediction", expected, prediction);
        next_cycle();
        check_bit("prediction_valid", 1'b0, prediction_valid); // one cycle wide only
    endtask

    task automatic run_corner(input feature_word_t word, input hidden_t expected_hidden);
        send_sample(word);
        next_cycle();
        check_hidden("hidden_reg", expected_hidden, tnn_classifier_inst.hidden_reg);
        wait_result(4);
        check_class("prediction", model_class(word), prediction);
        next_cycle();
    endtask

    task automatic test_corner_inputs();
        feature_word_t word;
        hidden_t       fired;
        int            tries;
        // with all features at zero both sums are 0, so only unweighted neurons stay low
        word.flat = '0;
        for (int n = 0; n < hidden_cnt; n++) begin
            fired[n] = |(pos_mask[n] | neg_mask[n]);
        end
        run_corner(word, fired);
        word.flat = '1;
        run_corner(word, model_hidden(word));
        // a word whose best score is shared by two classes makes argmax pick the lower one
        word.flat = random_word();
        tries     = 1;
        while (!top_score_tied(word) && tries < tie_search_limit) begin
            word.flat = random_word();
            tries++;
        end
        if (!top_score_tied(word)) begin
            $display("no feature word with a tied best score found in %0d tries", tries);
            $display("Simulation failed");
            $fatal(1);
        end
        run_corner(word, model_hidden(word));
    endtask

    task automatic test_random();
        feature_word_t word;
        class_t        expected;
        int            gap;
        repeat (random_count) begin
            word.flat = random_word();
            expected  = model_class(word);
            send_sample(word);
            wait_result(6);
            check_class("prediction", expected, prediction);
            next_cycle();
            check_bit("prediction_valid", 1'b0, prediction_valid);
            gap = int'($urandom_range(3, 0));
            repeat (gap) next_cycle();
        end
    endtask

    task automatic test_stream();
        feature_word_t word;
        class_t        expected_q [$];
        class_t        expected;
        int            sent;
        int            received;
        int            cycles;
        sent     = 0;
        received = 0;
        cycles   = 0;
        while (received < stream_count) begin
            if (sent < stream_count) begin
                word.flat = random_word();
                expected_q.push_back(model_class(word));
                features       = word;
                features_valid = 1'b1;
                sent++;
            end else begin
                features_valid = 1'b0;
            end
            next_cycle();
            cycles++;
            // the first result lands on the third edge, then one per cycle
            check_bit("prediction_valid", cycles >= 3, prediction_valid);
            if (prediction_valid) begin
                expected = expected_q.pop_front();
                check_class("prediction", expected, prediction);
                received++;
            end
        end
        next_cycle();
        check_bit("prediction_valid", 1'b0, prediction_valid);
    endtask

    task automatic test_hold();
        feature_word_t word;
        class_t        held;
        word.flat = random_word();
        send_sample(word);
        wait_result(6);
        held = prediction;
        check_class("prediction", model_class(word), held);
        repeat (12) begin
            features.flat = random_word(); // bus noise without a strobe
            next_cycle();
            check_bit("prediction_valid", 1'b0, prediction_valid);
            check_class("prediction", held, prediction);
        end
    endtask

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns before the tests completed", watchdog_ns);
        $display("Simulation failed");
        $fatal(1);
    end

    initial begin
        void'($urandom(12130));
        reset          = 1'b1;
        features       = '0;
        features_valid = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #(drive_delay);
        reset = 1'b0;

        test_reset();
        test_latency();
        test_corner_inputs();
        test_random();
        test_stream();
        test_hold();

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/tnn_cfg_pkg.sv
verilog/tnn_weights_pkg.sv
verilog/argmax.sv
verilog/feature_capture.sv
verilog/ternary_neuron.sv
verilog/class_scorer.sv
verilog/tnn_classifier.sv
tb/tnn_clock_gen.sv
tb/tnn_classifier_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the tnn_classifier testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tnn_classifier_tb \
    -Mdir obj_dir -o tnn_sim > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status, see build.log"
    exit 1
fi

./obj_dir/tnn_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "FAIL: testbench reported a failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "FAIL: simulator exited with status $sim_status"
    exit 1
fi

if ! grep -q "Simulation passed" sim.log; then
    echo "FAIL: simulation ended without a result"
    exit 1
fi

echo "PASS"
exit 0
